// ==== flist.f ====
+incdir+logic
logic/radarPkg.sv
logic/radarRegsIf.sv
logic/registerDecoder.sv
logic/triggerTiming.sv
logic/spiShifter.sv
logic/waveformLoader.sv
logic/adcReceiver.sv
logic/radar.sv
tests/radarTb.sv

// ==== logic/adcReceiver.sv ====
`include "radar_config.svh"

module adcReceiver (
  input  logic         clk,
  input  logic         reset,
  input  logic         trigger,
  radarRegsIf.receiver regs,
  output logic         adcSclk,
  output logic         adcNCs,
  output logic         adcDataIn,
  input  logic         adcDataOut
);
  import radarPkg::*;

  localparam int FrameBits = $clog2(`SAMPLE_COUNT + 1);

  typedef enum logic [1:0] {
    Idle,
    Select,    // chip select low before the shifter runs
    Transfer
  } tState;

  tState                state;
  logic [FrameBits-1:0] frame;
  tSampleSum            sum;
  tSampleSum            nextSum;
  tAdcFrame             command;
  tAdcFrame             reply;
  logic                 start;
  logic                 done;

  assign command = '{channel: regs.adcChannel, pad: '0, sample: '0};
  assign nextSum = sum + tSampleSum'(reply.sample);
  assign start   = (state == Select);
  assign adcNCs  = !((state == Select) || (state == Transfer && !done));

  spiShifter #(
    .tPayload(tAdcFrame)
  ) adcSpi (
    .clk   (clk       ),
    .reset (reset     ),
    .start (start     ),
    .txWord(command   ),
    .rxWord(reply     ),
    .sclk  (adcSclk   ),
    .mosi  (adcDataIn ),
    .miso  (adcDataOut),
    .busy  (          ),
    .done  (done      )
  );

  // ------------------------------
  // burst sequencing
  always_ff @(posedge clk) begin
    if (reset) begin
      state            <= Idle;
      frame            <= '0;
      sum              <= '0;
      regs.sampleSum   <= '0;
      regs.packetCount <= '0;
    end else begin
      case (state)
        Idle: if (trigger) begin
          state <= Select;
          frame <= '0;
          sum   <= '0;
        end
        Select: state <= Transfer;
        Transfer: if (done) begin
          sum   <= nextSum;
          frame <= frame + 1'b1;
          if (frame == FrameBits'(`SAMPLE_COUNT - 1)) begin
            regs.sampleSum   <= nextSum;              // publish the burst
            regs.packetCount <= regs.packetCount + 1'b1;
            state            <= Idle;
          end else begin
            state <= Select;                          // done cycle is the gap
          end
        end
        default: state <= Idle;
      endcase
    end
  end

endmodule

// ==== logic/radar.sv ====
module radar (
  input  logic              clk,
  input  logic              reset,

  // ------------------------------
  // register bus
  input  radarPkg::tRegAddr regAddress,
  input  radarPkg::tRegData regWriteData,
  input  logic              regWrite,
  input  logic              regRead,
  output radarPkg::tRegData regReadData,
  output logic              regReadValid,

  // ------------------------------
  // front end
  output logic              txEnable,

  output logic              synthSclk,
  output logic              synthData,
  output logic              synthLatch,
  output logic              synthTrigger,

  output logic              adcSclk,
  output logic              adcNCs,
  output logic              adcDataIn,
  input  logic              adcDataOut
);

  logic trigger;  // master trigger pulse

  radarRegsIf regs ();

  registerDecoder decoder (
    .clk         (clk         ),
    .reset       (reset       ),
    .regAddress  (regAddress  ),
    .regWriteData(regWriteData),
    .regWrite    (regWrite    ),
    .regRead     (regRead     ),
    .regReadData (regReadData ),
    .regReadValid(regReadValid),
    .regs        (regs.decoder)
  );

  triggerTiming timing (
    .clk     (clk        ),
    .reset   (reset      ),
    .regs    (regs.timing),
    .trigger (trigger    ),
    .txEnable(txEnable   )
  );

  waveformLoader waveform (
    .clk         (clk          ),
    .reset       (reset        ),
    .trigger     (trigger      ),
    .regs        (regs.waveform),
    .synthSclk   (synthSclk    ),
    .synthData   (synthData    ),
    .synthLatch  (synthLatch   ),
    .synthTrigger(synthTrigger )
  );

  adcReceiver receiver (
    .clk       (clk          ),
    .reset     (reset        ),
    .trigger   (trigger      ),
    .regs      (regs.receiver),
    .adcSclk   (adcSclk      ),
    .adcNCs    (adcNCs       ),
    .adcDataIn (adcDataIn    ),
    .adcDataOut(adcDataOut   )
  );

endmodule

// ==== logic/radarPkg.sv ====
`include "radar_config.svh"

package radarPkg;

  // ------------------------------
  // register bus
  typedef logic [3:0]  tRegAddr;
  typedef logic [31:0] tRegData;

  // ------------------------------
  // control values
  typedef logic [15:0] tCount;                        // period and tx length in cycles
  typedef logic [`SYNTH_WORD_BITS-1:0] tSynthWord;
  typedef logic [2:0]  tChannel;

  // one adc conversion frame
  // command uses channel only, reply uses sample only
  typedef struct packed {
    tChannel                                     channel; // top bits of the command
    logic [`ADC_FRAME_BITS-`SAMPLE_BITS-4:0]     pad;     // always zero
    logic [`SAMPLE_BITS-1:0]                     sample;  // bottom bits of the reply
  } tAdcFrame;

  // ------------------------------
  // status values
  typedef logic [15:0] tSampleSum;   // wraps at 16 bits
  typedef logic [15:0] tPacketCount;

endpackage

// ==== logic/radarRegsIf.sv ====
interface radarRegsIf;
  import radarPkg::*;

  // ------------------------------
  // controls written by software
  tCount       period;
  tCount       txLength;
  tSynthWord   synthWord;
  tChannel     adcChannel;

  // ------------------------------
  // status read by software
  tSampleSum   sampleSum;
  tPacketCount packetCount;

  modport decoder (
    output period, txLength, synthWord, adcChannel,
    input  sampleSum, packetCount
  );

  modport timing   (input period, txLength);

  modport waveform (input synthWord);

  modport receiver (
    input  adcChannel,
    output sampleSum, packetCount
  );

endinterface

// ==== logic/radar_config.svh ====
`ifndef RADAR_CONFIG_SVH
`define RADAR_CONFIG_SVH

// ------------------------------
// build identity
`define RADAR_VERSION    32'h0001_0000

// ------------------------------
// serial link widths
`define SYNTH_WORD_BITS  32  // synthesizer programming word
`define ADC_FRAME_BITS   16  // one conversion
`define SAMPLE_BITS      12  // adc resolution
`define SAMPLE_COUNT     4   // conversions per trigger

// ------------------------------
// register map
`define REG_VERSION      4'd0
`define REG_PERIOD       4'd1
`define REG_TX_LENGTH    4'd2
`define REG_SYNTH_WORD   4'd3
`define REG_ADC_CHANNEL  4'd4
`define REG_SAMPLE_SUM   4'd5
`define REG_PACKET_COUNT 4'd6

`endif

// ==== logic/registerDecoder.sv ====
`include "radar_config.svh"

module registerDecoder (
  input  logic              clk,
  input  logic              reset,

  input  radarPkg::tRegAddr regAddress,
  input  radarPkg::tRegData regWriteData,
  input  logic              regWrite,
  input  logic              regRead,
  output radarPkg::tRegData regReadData,
  output logic              regReadValid,

  radarRegsIf.decoder       regs
);
  import radarPkg::*;

  // ------------------------------
  // control registers
  always_ff @(posedge clk) begin
    if (reset) begin
      regs.period     <= '0;
      regs.txLength   <= '0;
      regs.synthWord  <= '0;
      regs.adcChannel <= '0;
    end else if (regWrite) begin
      case (regAddress)
        `REG_PERIOD:      regs.period     <= tCount'(regWriteData);
        `REG_TX_LENGTH:   regs.txLength   <= tCount'(regWriteData);
        `REG_SYNTH_WORD:  regs.synthWord  <= tSynthWord'(regWriteData);
        `REG_ADC_CHANNEL: regs.adcChannel <= tChannel'(regWriteData);
        default: ;                                    // read-only or unmapped
      endcase
    end
  end

  // ------------------------------
  // read path with one cycle latency
  always_ff @(posedge clk) begin
    if (reset) begin
      regReadValid <= 1'b0;
    end else begin
      regReadValid <= regRead;
    end
  end

  always_ff @(posedge clk) begin
    if (regRead) begin
      case (regAddress)
        `REG_VERSION:      regReadData <= `RADAR_VERSION;
        `REG_PERIOD:       regReadData <= tRegData'(regs.period);
        `REG_TX_LENGTH:    regReadData <= tRegData'(regs.txLength);
        `REG_SYNTH_WORD:   regReadData <= tRegData'(regs.synthWord);
        `REG_ADC_CHANNEL:  regReadData <= tRegData'(regs.adcChannel);
        `REG_SAMPLE_SUM:   regReadData <= tRegData'(regs.sampleSum);
        `REG_PACKET_COUNT: regReadData <= tRegData'(regs.packetCount);
        default:           regReadData <= '0;         // unmapped
      endcase
    end
  end

endmodule

// ==== logic/spiShifter.sv ====
module spiShifter #(
  parameter type tPayload = logic [7:0]
) (
  input  logic    clk,
  input  logic    reset,

  input  logic    start,
  input  tPayload txWord,
  output tPayload rxWord,

  output logic    sclk,
  output logic    mosi,
  input  logic    miso,

  output logic    busy,
  output logic    done
);
  localparam int Width     = $bits(tPayload);
  localparam int CountBits = (Width > 1) ? $clog2(Width) : 1;

  logic [Width-1:0]     shiftReg;  // tx out the top, rx in the bottom
  logic [CountBits-1:0] bitCount;
  logic                 phase;     // 0 = sclk low, 1 = sclk high

  // ------------------------------
  // bit sequencing
  always_ff @(posedge clk) begin
    if (reset) begin
      busy     <= 1'b0;
      phase    <= 1'b0;
      bitCount <= '0;
      done     <= 1'b0;
    end else begin
      done <= 1'b0;
      if (!busy) begin
        if (start) begin
          busy     <= 1'b1;
          phase    <= 1'b0;
          bitCount <= '0;
        end
      end else if (!phase) begin
        phase <= 1'b1;
      end else begin
        phase    <= 1'b0;
        bitCount <= bitCount + 1'b1;
        if (bitCount == CountBits'(Width - 1)) begin  // last high phase
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  // ------------------------------
  // data path
  always_ff @(posedge clk) begin
    if (!busy && start) begin
      shiftReg <= txWord;
    end else if (busy && phase) begin
      shiftReg <= {shiftReg[Width-2:0], miso};        // sample at end of high phase
    end
  end

  assign rxWord = tPayload'(shiftReg);
  assign sclk   = busy & phase;
  assign mosi   = busy & shiftReg[Width-1];         // msb first

endmodule

// ==== logic/triggerTiming.sv ====
module triggerTiming (
  input  logic       clk,
  input  logic       reset,
  radarRegsIf.timing regs,
  output logic       trigger,
  output logic       txEnable
);
  import radarPkg::*;

  tCount periodCount;
  tCount txCount;

  // ------------------------------
  // master trigger
  always_ff @(posedge clk) begin
    if (reset || regs.period == '0) begin             // zero period stops the trigger
      periodCount <= '0;
      trigger     <= 1'b0;
    end else if (periodCount >= regs.period - 1'b1) begin
      periodCount <= '0;
      trigger     <= 1'b1;
    end else begin
      periodCount <= periodCount + 1'b1;
      trigger     <= 1'b0;
    end
  end

  // ------------------------------
  // transmit window
  always_ff @(posedge clk) begin
    if (reset) begin
      txCount <= '0;
    end else if (trigger) begin
      txCount <= regs.txLength;                       // window starts next cycle
    end else if (txCount != '0) begin
      txCount <= txCount - 1'b1;
    end
  end

  assign txEnable = (txCount != '0);

endmodule

// ==== logic/waveformLoader.sv ====
module waveformLoader (
  input  logic         clk,
  input  logic         reset,
  input  logic         trigger,
  radarRegsIf.waveform regs,
  output logic         synthSclk,
  output logic         synthData,
  output logic         synthLatch,
  output logic         synthTrigger
);
  import radarPkg::*;

  typedef enum logic [1:0] {
    Idle,
    Shift,
    Latch,
    Fire
  } tState;

  tState state;
  logic  start;
  logic  done;

  assign start = (state == Idle) && trigger;          // busy triggers are dropped

  spiShifter #(
    .tPayload(tSynthWord)
  ) synthSpi (
    .clk   (clk           ),
    .reset (reset         ),
    .start (start         ),
    .txWord(regs.synthWord),
    .rxWord(              ),
    .sclk  (synthSclk     ),
    .mosi  (synthData     ),
    .miso  (1'b0          ),
    .busy  (              ),
    .done  (done          )
  );

  // ------------------------------
  // programming sequence
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= Idle;
    end else begin
      case (state)
        Idle:    if (start) state <= Shift;
        Shift:   if (done) state <= Latch;
        Latch:   state <= Fire;
        default: state <= Idle;
      endcase
    end
  end

  assign synthLatch   = (state == Latch);
  assign synthTrigger = (state == Fire);

endmodule

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
verilator --binary --timing -Wno-fatal -f flist.f --top-module radarTb -o radarSim \
  && ./obj_dir/radarSim | tee /dev/stderr | grep -F '** PASS **' > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== tests/radarTb.sv ====
`include "radar_config.svh"

module radarTb;
  import radarPkg::*;

  localparam int PeriodA       = 200;
  localparam int PeriodB       = 260;
  localparam int Triggers      = 3;   // bursts per period setting
  localparam int TimeoutCycles = 2 * Triggers * (PeriodA + PeriodB);

  logic      clk;
  logic      reset;
  tRegAddr   regAddress;
  tRegData   regWriteData;
  logic      regWrite;
  logic      regRead;
  tRegData   regReadData;
  logic      regReadValid;
  logic      txEnable;
  logic      synthSclk;
  logic      synthData;
  logic      synthLatch;
  logic      synthTrigger;
  logic      adcSclk;
  logic      adcNCs;
  logic      adcDataIn;
  logic      adcDataOut;

  integer    seed;
  int        errors;
  int        reads;
  int        bursts;
  int        cycles;
  int        framesBefore;

  // expected values follow each register write
  int        expPeriod;
  int        expLength;
  tSynthWord expSynthWord;
  tChannel   expChannel;
  logic      quiet;      // high once the period is zero
  logic      haveRise;

  radar i_radar (.*);

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // ------------------------------
  // reference model
  logic [`SAMPLE_BITS-1:0] sampleLog [0:63];
  int                      sampleIndex;

  function automatic logic synthStreamBit(input tSynthWord word, input int index);
    return word[`SYNTH_WORD_BITS-1-index];  // msb leaves first
  endfunction

  function automatic tSampleSum referenceSum(input int burst);
    int          i;
    logic [31:0] total;
    total = '0;
    for (i = 0; i < `SAMPLE_COUNT; i++) begin
      total = total + 32'(sampleLog[burst*`SAMPLE_COUNT + i]);
    end
    return total[15:0];  // wraps like the status register
  endfunction

  task automatic reportError(input string msg);
    errors++;
    $display("FAIL %0t: %s", $time, msg);
  endtask

  // ------------------------------
  // adc model
  logic                       modelNCs;
  logic                       modelSclk;
  logic [`ADC_FRAME_BITS-1:0] replyWord;
  logic [`ADC_FRAME_BITS-1:0] cmdWord;
  int                         bitIndex;
  int                         cmdBits;

  always @(negedge clk) begin
    if (modelNCs && !adcNCs) begin  // new conversion
      replyWord = {{(`ADC_FRAME_BITS-`SAMPLE_BITS){1'b0}}, `SAMPLE_BITS'($random(seed))};
      sampleLog[sampleIndex] = replyWord[`SAMPLE_BITS-1:0];
      sampleIndex++;
      bitIndex   = `ADC_FRAME_BITS - 1;
      adcDataOut = replyWord[bitIndex];
      cmdWord    = '0;
      cmdBits    = 0;
    end else if (modelSclk && bitIndex > 0) begin  // next bit after a high phase
      bitIndex--;
      adcDataOut = replyWord[bitIndex];
    end
    if (adcSclk) begin
      cmdWord = {cmdWord[`ADC_FRAME_BITS-2:0], adcDataIn};
      cmdBits++;
    end
    modelNCs  = adcNCs;
    modelSclk = adcSclk;
  end

  // ------------------------------
  // stream checks
  logic prevLatch;
  logic prevTrigger;
  logic prevTx;
  logic prevNCs;
  int   synthBits;
  int   synthFires;
  int   txRises;
  int   lastRise;
  int   windowLen;
  int   adcFrames;

  always @(negedge clk) begin
    if (!reset) begin
      if (synthSclk) begin
        if (synthData !== synthStreamBit(expSynthWord, synthBits))
          reportError($sformatf("synthData bit %0d wrong", synthBits));
        synthBits++;
      end
      if (synthLatch) begin
        if (prevLatch) reportError("synthLatch high for more than one cycle");
        if (synthBits != `SYNTH_WORD_BITS)
          reportError($sformatf("%0d synth bits before latch", synthBits));
        synthBits = 0;
      end
      if (synthTrigger) begin
        if (!prevLatch || synthLatch || prevTrigger)
          reportError("synthTrigger not a single cycle after synthLatch");
        synthFires++;
      end
      if (txEnable && !prevTx) begin  // window opens
        if (quiet) reportError("txEnable rose with period zero");
        if (haveRise && cycles - lastRise != expPeriod)
          reportError($sformatf("trigger spacing %0d, expected %0d", cycles - lastRise,
                                expPeriod));
        lastRise  = cycles;
        haveRise  = 1'b1;
        windowLen = 0;
        txRises++;
      end
      if (txEnable) windowLen++;
      if (!txEnable && prevTx && windowLen != expLength)
        reportError($sformatf("tx window %0d cycles, expected %0d", windowLen, expLength));
      if (adcNCs && !prevNCs) begin  // frame ends
        if (cmdBits != `ADC_FRAME_BITS)
          reportError($sformatf("adc frame had %0d clocked bits", cmdBits));
        if (cmdWord[`ADC_FRAME_BITS-1 -: 3] !== expChannel)
          reportError($sformatf("adc channel %0d, expected %0d",
                                cmdWord[`ADC_FRAME_BITS-1 -: 3], expChannel));
        adcFrames++;
      end
    end
    prevLatch   = synthLatch;
    prevTrigger = synthTrigger;
    prevTx      = txEnable;
    prevNCs     = adcNCs;
  end

  // ------------------------------
  // register access
  task automatic writeReg(input tRegAddr addr, input tRegData data);
    @(negedge clk);
    regAddress   = addr;
    regWriteData = data;
    regWrite     = 1'b1;
    @(negedge clk);
    regWrite     = 1'b0;
  endtask

  task automatic readCheck(input tRegAddr addr, input tRegData expected, input string name);
    @(negedge clk);
    if (regReadValid !== 1'b0) reportError("regReadValid high without a read");
    regAddress = addr;
    regRead    = 1'b1;
    @(negedge clk);
    regRead    = 1'b0;
    reads++;
    if (regReadValid !== 1'b1)
      reportError($sformatf("no regReadValid for %s", name));
    else if (regReadData !== expected)
      reportError($sformatf("%s read %h, expected %h", name, regReadData, expected));
  endtask

  task automatic runPhase(input int period, input int length, input tSynthWord word,
                          input tChannel channel);
    int target;
    expLength    = length;
    expSynthWord = word;
    expChannel   = channel;
    writeReg(`REG_TX_LENGTH, tRegData'(length));
    writeReg(`REG_SYNTH_WORD, word);
    writeReg(`REG_ADC_CHANNEL, tRegData'(channel));
    expPeriod = period;
    haveRise  = 1'b0;  // spacing restarts with the new period
    writeReg(`REG_PERIOD, tRegData'(period));
    repeat (Triggers) begin
      target = `SAMPLE_COUNT * (bursts + 1);
      while (adcFrames < target) @(negedge clk);
      bursts++;
      if (adcFrames != `SAMPLE_COUNT * synthFires)
        reportError("adc frame count does not match the trigger count");
      readCheck(`REG_SAMPLE_SUM, tRegData'(referenceSum(bursts - 1)), "sample sum");
      readCheck(`REG_PACKET_COUNT, tRegData'(bursts), "packet count");
    end
  endtask

  // ------------------------------
  // timeout
  initial begin
    cycles = 0;
    while (cycles < TimeoutCycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: simulation did not finish");
    $display("** FAIL **");
    $finish;
  end

  initial begin
    seed         = 32'hf94c;
    reset        = 1'b1;
    regAddress   = '0;
    regWriteData = '0;
    regWrite     = 1'b0;
    regRead      = 1'b1;  // valid must still read low once reset ends
    adcDataOut   = 1'b0;
    modelNCs     = 1'b1;
    modelSclk    = 1'b0;
    prevLatch    = 1'b0;
    prevTrigger  = 1'b0;
    prevTx       = 1'b0;
    prevNCs      = 1'b1;
    quiet        = 1'b0;
    haveRise     = 1'b0;
    expPeriod    = 0;
    expLength    = 0;
    expSynthWord = '0;
    expChannel   = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset   = 1'b0;
    regRead = 1'b0;
    if (adcNCs !== 1'b1 || adcSclk !== 1'b0 || synthSclk !== 1'b0 || synthLatch !== 1'b0
        || synthTrigger !== 1'b0 || txEnable !== 1'b0 || regReadValid !== 1'b0)
      reportError("outputs not inactive after reset");

    // register readback well inside the written period
    readCheck(`REG_VERSION, `RADAR_VERSION, "version");
    writeReg(`REG_VERSION, 32'h1234_5678);
    readCheck(`REG_VERSION, `RADAR_VERSION, "version after write");
    writeReg(`REG_PERIOD, 32'h0000_5a5a);
    writeReg(`REG_TX_LENGTH, 32'h0000_00a5);
    writeReg(`REG_SYNTH_WORD, 32'hdead_beef);
    writeReg(`REG_ADC_CHANNEL, 32'h0000_0005);
    readCheck(`REG_PERIOD, 32'h0000_5a5a, "period");
    readCheck(`REG_TX_LENGTH, 32'h0000_00a5, "tx length");
    readCheck(`REG_SYNTH_WORD, 32'hdead_beef, "synth word");
    readCheck(`REG_ADC_CHANNEL, 32'h0000_0005, "adc channel");
    readCheck(4'd9, '0, "unmapped address");
    readCheck(`REG_SAMPLE_SUM, '0, "sample sum after reset");
    readCheck(`REG_PACKET_COUNT, '0, "packet count after reset");
    writeReg(`REG_PERIOD, '0);

    runPhase(PeriodA, 30, 32'ha5c3_0f96, 3'd5);
    runPhase(PeriodB, 45, 32'h3c69_e1b4, 3'd2);

    writeReg(`REG_PERIOD, '0);
    quiet        = 1'b1;
    framesBefore = adcFrames;
    repeat (PeriodB) @(negedge clk);
    if (txEnable !== 1'b0 || adcFrames != framesBefore)
      reportError("activity after the period was set to zero");
    if (txRises != synthFires)
      reportError($sformatf("%0d tx windows for %0d triggers", txRises, synthFires));

    $display("errors: %0d  reads: %0d  bursts: %0d  tx windows: %0d",
             errors, reads, bursts, txRises);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule
